/* edt_decompressor.f */
verilog/edt_pkg.sv
verilog/ring_generator.sv
verilog/phase_shifter.sv
verilog/shift_counter.sv
verilog/edt_controller.sv
verilog/edt_decompressor.sv
verif/tb_edt_decompressor.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the EDT decompressor testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tb_edt_decompressor
FILE_LIST=edt_decompressor.f
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module "$TOP" \
	-f "$FILE_LIST" \
	--Mdir "$OBJ_DIR" \
	-o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

grep -qx "TEST OK" "$LOG"
status=$?
if [ $status -eq 0 ]; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see $LOG"
exit 1

/* verif/tb_edt_decompressor.sv */
////////////////////////////////////////
// Random-stimulus testbench for the EDT decompressor
// Runs a stream of patterns with random injector data
// and checks every cycle against a ring and phase-shifter model
////////////////////////////////////////

module tb_edt_decompressor
	import edt_pkg::*;
();

	localparam int CHAINS       = 16;
	localparam int CHAIN_LEN    = 24;
	localparam int INIT_CYCLES  = 6;
	localparam int NUM_PATTERNS = 20;
	localparam int SEED         = 29927;
	// Worst pattern is gap plus start plus init, shift and capture
	localparam int CYCLE_LIMIT  = NUM_PATTERNS * (INIT_CYCLES + CHAIN_LEN + 8) + 100;

	// Model phases
	localparam int M_IDLE    = 0;
	localparam int M_INIT    = 1;
	localparam int M_SHIFT   = 2;
	localparam int M_CAPTURE = 3;

	// DUT ports
	logic                 i_clk = 1'b0;
	logic                 i_rst;
	logic                 i_start;
	logic [INJ_WIDTH-1:0] i_inject;
	logic                 o_busy;
	logic                 o_shift_en;
	logic [CHAINS-1:0]    o_scan_in;
	logic                 o_capture;
	logic                 o_done;

	// Model state
	int                    m_phase;
	int                    m_left;
	logic [RING_WIDTH-1:0] m_ring;

	// Bookkeeping
	int   error_count = 0;
	int   cycle_count = 0;
	int   done_count  = 0;
	int   shift_run   = 0;
	logic seen_done;

	always #5 i_clk = ~i_clk;

	edt_decompressor #(
		.CHAINS      (CHAINS),
		.CHAIN_LEN   (CHAIN_LEN),
		.INIT_CYCLES (INIT_CYCLES)
	) dut0 (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_inject   (i_inject),
		.o_busy     (o_busy),
		.o_shift_en (o_shift_en),
		.o_scan_in  (o_scan_in),
		.o_capture  (o_capture),
		.o_done     (o_done)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// One ring step from the polynomial and injector rules
	function automatic logic [RING_WIDTH-1:0] ring_step(input logic [RING_WIDTH-1:0] r,
		input logic [INJ_WIDTH-1:0] inj);
		logic [RING_WIDTH-1:0] n;
		// Each stage takes its upper neighbor, stage 31 wraps from 0
		for (int s = 0; s < RING_WIDTH; s++) begin
			n[s] = r[(s + 1) % RING_WIDTH];
		end
		// Feedback taps
		n[17] = n[17] ^ r[13];
		n[20] = n[20] ^ r[11];
		n[23] = n[23] ^ r[8];
		n[25] = n[25] ^ r[5];
		n[28] = n[28] ^ r[2];
		// Injectors on the even stages 0 to 14
		for (int k = 0; k < INJ_WIDTH; k++) begin
			n[2*k] = n[2*k] ^ inj[k];
		end
		return n;
	endfunction

	// Three taps per chain at offsets 0, 9 and 19
	function automatic logic [CHAINS-1:0] phase_map(input logic [RING_WIDTH-1:0] r);
		logic [CHAINS-1:0] out;
		for (int j = 0; j < CHAINS; j++) begin
			out[j] = r[j] ^ r[(j + 9) % RING_WIDTH] ^ r[(j + 19) % RING_WIDTH];
		end
		return out;
	endfunction

	// Advance the model across the coming rising edge
	task automatic model_edge();
		case (m_phase)
			M_IDLE: begin
				if (i_start) begin
					m_ring  = '0;
					m_phase = M_INIT;
					m_left  = INIT_CYCLES;
				end
			end
			M_INIT, M_SHIFT: begin
				m_ring = ring_step(m_ring, i_inject);
				m_left = m_left - 1;
				if (m_left == 0) begin
					m_phase = (m_phase == M_INIT) ? M_SHIFT : M_CAPTURE;
					m_left  = CHAIN_LEN;
				end
			end
			// Ring holds through capture
			default: m_phase = M_IDLE;
		endcase
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		error_count++;
		$display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
	endtask

	task automatic check_outputs();
		logic              exp_busy;
		logic              exp_shift;
		logic              exp_cap;
		logic [CHAINS-1:0] exp_scan;
		exp_busy  = (m_phase != M_IDLE);
		exp_shift = (m_phase == M_SHIFT);
		exp_cap   = (m_phase == M_CAPTURE);
		if (o_busy !== exp_busy) report_mismatch("o_busy", 32'(exp_busy), 32'(o_busy));
		if (o_shift_en !== exp_shift) report_mismatch("o_shift_en", 32'(exp_shift), 32'(o_shift_en));
		if (o_capture !== exp_cap) report_mismatch("o_capture", 32'(exp_cap), 32'(o_capture));
		if (o_done !== exp_cap) report_mismatch("o_done", 32'(exp_cap), 32'(o_done));
		// Scan data only matters while the chains shift
		if (exp_shift) begin
			exp_scan = phase_map(m_ring);
			if (o_scan_in !== exp_scan) report_mismatch("o_scan_in", 32'(exp_scan), 32'(o_scan_in));
		end
		// Length of each shift window
		if (o_shift_en === 1'b1) begin
			shift_run++;
		end else if (shift_run != 0) begin
			if (shift_run != CHAIN_LEN) begin
				error_count++;
				$display("Shift window at %0t lasted %0d cycles instead of %0d",
					$time, shift_run, CHAIN_LEN);
			end
			shift_run = 0;
		end
		if (o_done === 1'b1) begin
			seen_done = 1'b1;
			done_count++;
		end
	endtask

	// Check on the falling edge, then drive the next inputs
	task automatic step(input logic start);
		@(negedge i_clk);
		check_outputs();
		i_start  = start;
		i_inject = INJ_WIDTH'($urandom);
		model_edge();
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		int gap;
		void'($urandom(SEED));
		i_rst     = 1'b1;
		i_start   = 1'b0;
		i_inject  = '0;
		m_phase   = M_IDLE;
		m_left    = 0;
		m_ring    = '0;
		seen_done = 1'b0;
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;

		for (int p = 0; p < NUM_PATTERNS; p++) begin
			// Idle gap, outputs must stay quiet
			gap = int'($urandom % 6);
			repeat (gap) step(1'b0);
			seen_done = 1'b0;
			step(1'b1);
			// Stray starts while busy must be ignored
			while (!seen_done) begin
				step(($urandom % 5) == 0);
			end
		end
		// Back in idle after the last capture
		step(1'b0);

		if (done_count != NUM_PATTERNS) begin
			error_count++;
			$display("Saw %0d done pulses for %0d patterns", done_count, NUM_PATTERNS);
		end
		$display("Run finished: %0d patterns, %0d errors", done_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	always @(posedge i_clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the patterns did not complete", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

/* verilog/edt_controller.sv */
////////////////////////////////////////
// Pattern sequencer for the decompressor
// Runs clear, init, shift and capture per start
////////////////////////////////////////

module edt_controller
	import edt_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_start,
	input  logic i_last,
	output logic o_ring_clr,
	output logic o_ring_en,
	output logic o_cnt_load_init,
	output logic o_cnt_load_shift,
	output logic o_cnt_en,
	output logic o_busy,
	output logic o_shift_en,
	output logic o_capture,
	output logic o_done
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (i_start) begin
					state_d = ST_INIT;
				end
			end
			ST_INIT: begin
				if (i_last) begin
					state_d = ST_SHIFT;
				end
			end
			ST_SHIFT: begin
				if (i_last) begin
					state_d = ST_CAPTURE;
				end
			end
			// Capture is always a single cycle
			ST_CAPTURE: state_d = ST_IDLE;
			default:    state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	// Start acceptance, only seen while idle
	assign o_ring_clr      = (state_q == ST_IDLE) && i_start;
	assign o_cnt_load_init = (state_q == ST_IDLE) && i_start;

	// Ring and counter both run through init and shift
	assign o_ring_en = (state_q == ST_INIT) || (state_q == ST_SHIFT);
	assign o_cnt_en  = (state_q == ST_INIT) || (state_q == ST_SHIFT);

	// Hand over to the shift length on the last init cycle
	assign o_cnt_load_shift = (state_q == ST_INIT) && i_last;

	// Handshake levels and strobes
	assign o_busy     = (state_q != ST_IDLE);
	assign o_shift_en = (state_q == ST_SHIFT);
	assign o_capture  = (state_q == ST_CAPTURE);
	assign o_done     = (state_q == ST_CAPTURE);

endmodule

/* verilog/edt_decompressor.sv */
////////////////////////////////////////
// EDT decompressor top level
// Tester data on i_inject, scan-in bits on o_scan_in
////////////////////////////////////////

module edt_decompressor
	import edt_pkg::*;
#(
	parameter int CHAINS      = 16,
	parameter int CHAIN_LEN   = 24,
	parameter int INIT_CYCLES = 6
) (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  logic [INJ_WIDTH-1:0] i_inject,
	output logic                 o_busy,
	output logic                 o_shift_en,
	output logic [CHAINS-1:0]    o_scan_in,
	output logic                 o_capture,
	output logic                 o_done
);

	// Controller strobes
	logic ring_clr;
	logic ring_en;
	logic cnt_load_init;
	logic cnt_load_shift;
	logic cnt_en;
	// Counter feedback
	logic cnt_last;
	// Ring to phase shifter
	logic [RING_WIDTH-1:0] ring_state;

	////////////////////////////////////////
	// Control path
	////////////////////////////////////////

	edt_controller u_ctrl (
		.i_clk            (i_clk),
		.i_rst            (i_rst),
		.i_start          (i_start),
		.i_last           (cnt_last),
		.o_ring_clr       (ring_clr),
		.o_ring_en        (ring_en),
		.o_cnt_load_init  (cnt_load_init),
		.o_cnt_load_shift (cnt_load_shift),
		.o_cnt_en         (cnt_en),
		.o_busy           (o_busy),
		.o_shift_en       (o_shift_en),
		.o_capture        (o_capture),
		.o_done           (o_done)
	);

	shift_counter #(
		.INIT_CYCLES (INIT_CYCLES),
		.CHAIN_LEN   (CHAIN_LEN)
	) u_cnt (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_load_init  (cnt_load_init),
		.i_load_shift (cnt_load_shift),
		.i_en         (cnt_en),
		.o_last       (cnt_last)
	);

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	ring_generator u_ring (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_clr    (ring_clr),
		.i_en     (ring_en),
		.i_inject (i_inject),
		.o_state  (ring_state)
	);

	// Zero latency, scan-in follows the current ring state
	phase_shifter #(
		.CHAINS (CHAINS)
	) u_ps (
		.i_state  (ring_state),
		.o_chains (o_scan_in)
	);

endmodule

/* verilog/edt_pkg.sv */
////////////////////////////////////////
// Shared constants and types for the EDT decompressor
// Import with a wildcard in the module header
////////////////////////////////////////

package edt_pkg;

	////////////////////////////////////////
	// Ring generator geometry
	////////////////////////////////////////

	// Fixed by x32 + x27 + x21 + x16 + x10 + x5 + 1
	localparam int RING_WIDTH = 32;

	// Tester channels, injected at even stages 0 to 14
	localparam int INJ_WIDTH = 8;

	////////////////////////////////////////
	// Controller
	////////////////////////////////////////

	// One pattern walks through all four states in order
	typedef enum logic [1:0] {
		// Waiting for a start pulse
		ST_IDLE    = 2'd0,
		// Ring loading, chains hold
		ST_INIT    = 2'd1,
		// Chains shift, injection continues
		ST_SHIFT   = 2'd2,
		// Single capture cycle, ring holds
		ST_CAPTURE = 2'd3
	} ctrl_state_t;

endpackage

/* verilog/phase_shifter.sv */
////////////////////////////////////////
// Phase shifter from ring state to scan-in bits
// Purely combinational, one output per scan chain
////////////////////////////////////////

module phase_shifter
	import edt_pkg::*;
#(
	parameter int CHAINS = 16
) (
	input  logic [RING_WIDTH-1:0] i_state,
	output logic [CHAINS-1:0]     o_chains
);

	// Tap offsets relative to the chain index
	localparam int TAP_A = 0;
	localparam int TAP_B = 9;
	localparam int TAP_C = 19;

	////////////////////////////////////////
	// Three-tap XOR per chain
	////////////////////////////////////////

	// Neighboring ring stages are shifted copies of each other,
	// mixing three distant stages breaks that correlation
	// between adjacent chains
	for (genvar j = 0; j < CHAINS; j++) begin : g_chain
		// Stage indices wrap around the ring
		localparam int IDX_A = (j + TAP_A) % RING_WIDTH;
		localparam int IDX_B = (j + TAP_B) % RING_WIDTH;
		localparam int IDX_C = (j + TAP_C) % RING_WIDTH;

		assign o_chains[j] = i_state[IDX_A] ^ i_state[IDX_B] ^ i_state[IDX_C];
	end

endmodule

/* verilog/ring_generator.sv */
////////////////////////////////////////
// 32-stage ring generator with eight injectors
// Clear starts a pattern, enable advances the ring
////////////////////////////////////////

module ring_generator
	import edt_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_clr,
	input  logic                  i_en,
	input  logic [INJ_WIDTH-1:0]  i_inject,
	output logic [RING_WIDTH-1:0] o_state
);

	// Stage registers
	logic [RING_WIDTH-1:0] ring_q;
	// Value after the next enabled edge
	logic [RING_WIDTH-1:0] ring_next;

	////////////////////////////////////////
	// Next-state logic
	////////////////////////////////////////

	always_comb begin
		// Plain shift toward stage 0, stage 31 wraps from stage 0
		ring_next = {ring_q[0], ring_q[RING_WIDTH-1:1]};

		// Polynomial feedback taps in the lower half
		ring_next[17] = ring_q[18] ^ ring_q[13];
		ring_next[20] = ring_q[21] ^ ring_q[11];
		ring_next[23] = ring_q[24] ^ ring_q[8];
		ring_next[25] = ring_q[26] ^ ring_q[5];
		ring_next[28] = ring_q[29] ^ ring_q[2];

		// Injector k lands on stage 2k
		for (int k = 0; k < INJ_WIDTH; k++) begin
			ring_next[2*k] = ring_next[2*k] ^ i_inject[k];
		end
	end

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			ring_q <= '0;
		end else if (i_clr) begin
			// Clear wins over enable
			ring_q <= '0;
		end else if (i_en) begin
			ring_q <= ring_next;
		end
	end

	assign o_state = ring_q;

endmodule

/* verilog/shift_counter.sv */
////////////////////////////////////////
// Phase length down-counter
// Load a phase, enable each cycle, watch o_last
////////////////////////////////////////

module shift_counter #(
	parameter int INIT_CYCLES = 6,
	parameter int CHAIN_LEN   = 24
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_load_init,
	input  logic i_load_shift,
	input  logic i_en,
	output logic o_last
);

	// Wide enough for the longer phase
	localparam int MAX_LEN = (CHAIN_LEN > INIT_CYCLES) ? CHAIN_LEN : INIT_CYCLES;
	localparam int CNT_W   = $clog2(MAX_LEN + 1);

	logic [CNT_W-1:0] cnt_q;

	////////////////////////////////////////
	// Count register
	////////////////////////////////////////

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			cnt_q <= '0;
		end else if (i_load_init) begin
			cnt_q <= CNT_W'(INIT_CYCLES);
		end else if (i_load_shift) begin
			// Loaded on the last init cycle, overrides the decrement
			cnt_q <= CNT_W'(CHAIN_LEN);
		end else if (i_en && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Count of one marks the final cycle of the phase
	assign o_last = (cnt_q == CNT_W'(1));

endmodule
